//--- ifetch.f
+incdir+hdl
hdl/ifetch_pkg.sv
hdl/icache_if.sv
hdl/icache_mem.sv
hdl/icache_ctrl.sv
hdl/fetch_stage.sv
hdl/ifetch_top.sv
tests/mem_model.sv
tests/ifetch_tb.sv

//--- Bender.yml
package:
  name: ifetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ifetch_pkg.sv
      - hdl/icache_if.sv
      - hdl/icache_mem.sv
      - hdl/icache_ctrl.sv
      - hdl/fetch_stage.sv
      - hdl/ifetch_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - tests/mem_model.sv
      - tests/ifetch_tb.sv

//--- tests/ifetch_testdata.txt
# w <byte addr> <word>: memory image, unlisted words read as zero; all fields hex
# r <fetch count> <pc>: redirect; s <fetch count> <cycles>: stall; e <fetch count>: end
w 0000 00000093
w 0004 00100113
w 0008 00208193
w 000c 40110233
w 0010 0041a2b3
w 0014 00520333
w 001c 0062f3b3
w 02a0 00a00513
w 02a4 00b00593
w 02a8 00c58633
w 02ac fff60613
w 0100 00d00693
w 0104 00e00713
w 0108 00e687b3
r 06 02a0
s 08 05
r 0a 0008
s 0c 03
r 10 0100
e 16

//--- tests/ifetch_tb.sv
/*
 * testbench for the instruction fetch front end
 * image and redirect/stall script from the data file,
 * expected fetch stream from the pc rules
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module ifetch_tb;

	localparam int image_words   = 16384;
	localparam int max_events    = 16;
	localparam int fetch_timeout = 400;
	localparam int run_limit     = 20000;

	logic                        clock;
	logic                        rst_n;
	logic                        stall;
	logic                        redirect_valid;
	logic [`IF_XLEN-1:0]         redirect_pc;
	ifetch_pkg::mem_command_e    mem_command;
	logic [`IF_XLEN-1:0]         mem_addr;
	logic [`IF_BLOCK_BITS-1:0]   mem_data;
	logic [1:0]                  mem_size;
	logic [`IF_MEM_TAG_BITS-1:0] mem_response;
	logic [`IF_MEM_TAG_BITS-1:0] mem_tag;
	logic [`IF_BLOCK_BITS-1:0]   mem_data_in;
	logic                        fetch_valid;
	logic [`IF_XLEN-1:0]         fetch_pc;
	logic [`IF_XLEN-1:0]         fetch_inst;

	// image and script from the data file
	logic [`IF_XLEN-1:0] exp_words [image_words];
	logic [7:0]          ev_kind [max_events];
	logic [31:0]         ev_at [max_events];
	logic [31:0]         ev_arg [max_events];
	int                  n_events;
	int                  end_fetches;

	int                  errors;
	int                  test_errors_at;
	int                  tests_run;
	int                  tests_failed;
	int                  loads;
	int                  refusals;
	int                  fetches;
	int                  ev;
	int                  stall_left;
	int                  idle;
	int                  cycles;
	bit                  timed_out;
	bit                  after_redirect;
	logic [`IF_XLEN-1:0] exp_pc;

	// tb view of cache residency for the load monitor
	bit                  held;
	logic [`IF_XLEN-1:0] held_addr;
	logic [12:0]         res_blk [`IF_LINES];
	bit                  res_valid [`IF_LINES];

	always #2 clock = ~clock;

	ifetch_top ifetch_top_inst (
		.clock (clock), .rst_n (rst_n), .stall (stall),
		.redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
		.mem_command (mem_command), .mem_addr (mem_addr), .mem_data (mem_data),
		.mem_size (mem_size), .mem_response (mem_response), .mem_tag (mem_tag),
		.mem_data_in (mem_data_in), .fetch_valid (fetch_valid),
		.fetch_pc (fetch_pc), .fetch_inst (fetch_inst)
	);

	mem_model mem_model_inst (
		.clock (clock), .rst_n (rst_n), .mem_command (mem_command),
		.mem_addr (mem_addr), .mem_response (mem_response),
		.mem_tag (mem_tag), .mem_data_in (mem_data_in)
	);

	task automatic report_mismatch(input string msg);
		$display("Fail %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string what);
		tests_run++;
		if (errors > test_errors_at) begin
			tests_failed++;
			$display("test %0d, %s: failed, %0d errors",
				tests_run, what, errors - test_errors_at);
		end else begin
			$display("test %0d, %s: ok", tests_run, what);
		end
		test_errors_at = errors;
	endtask

	// w addr word, r count pc, s count cycles, e count
	task automatic read_script();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  kind;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("tests/ifetch_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the data file tests/ifetch_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				kind = 8'h00;
				n = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%c %h %h", kind, a, b);
				end
				if (kind == "w") begin
					exp_words[a[15:2]] = b;
					mem_model_inst.put_word(a, b);
				end else if ((kind == "r" || kind == "s") && n_events < max_events) begin
					ev_kind[n_events] = kind;
					ev_at[n_events]   = a;
					ev_arg[n_events]  = b;
					n_events++;
				end else if (kind == "e") begin
					end_fetches = a;
				end
			end
			$fclose(fd);
		end
	endtask

	////////////////////
	// load request monitor
	////////////////////

	always @(posedge clock) begin
		if (rst_n && mem_command == ifetch_pkg::cmd_load) begin
			// loads carry no data and move a whole block
			if (mem_data !== '0 || mem_size !== `IF_MEM_SIZE_DOUBLE) begin
				report_mismatch($sformatf("load with mem_data %h and mem_size %h",
					mem_data, mem_size));
			end
			if (held && mem_addr !== held_addr) begin
				report_mismatch($sformatf("request moved from %h to %h after refusal",
					held_addr, mem_addr));
			end else if (!held) begin
				loads++;
				if (mem_addr[2:0] !== 3'b000) begin
					report_mismatch($sformatf("load address %h not block aligned", mem_addr));
				end
				// no second load for a block still in the cache
				if (res_valid[mem_addr[7:3]] && res_blk[mem_addr[7:3]] == mem_addr[15:3]) begin
					report_mismatch($sformatf("load for resident block %h", mem_addr));
				end
				res_valid[mem_addr[7:3]] = 1'b1;
				res_blk[mem_addr[7:3]]   = mem_addr[15:3];
			end
			if (mem_response == '0) begin
				refusals++;
			end
			held      = (mem_response == '0);
			held_addr = mem_addr;
		end else if (rst_n) begin
			if (held) begin
				report_mismatch("load dropped from the bus while refused");
			end
			held = 1'b0;
		end
	end

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		{errors, test_errors_at, tests_run, tests_failed} = '0;
		{loads, refusals, n_events, end_fetches} = '0;
		held = 1'b0;
		for (int i = 0; i < image_words; i++) begin
			exp_words[i] = '0;
		end
		for (int i = 0; i < `IF_LINES; i++) begin
			res_valid[i] = 1'b0;
		end
		mem_model_inst.clear_image();
		read_script();

		// outputs stay quiet through reset
		repeat (16) begin
			@(negedge clock);
			if (fetch_valid !== 1'b0 || mem_command !== ifetch_pkg::cmd_none) begin
				report_mismatch("fetch_valid or mem_command active during reset");
			end
		end
		rst_n = 1'b1;
		finish_test("reset state");

		fetches = 0;
		exp_pc = `IF_RESET_PC;
		{ev, stall_left, idle, cycles} = '0;
		timed_out = 1'b0;
		after_redirect = 1'b0;
		while (fetches < end_fetches && !timed_out) begin
			@(negedge clock);
			cycles++;
			redirect_valid = 1'b0;
			if (fetch_valid === 1'b1) begin
				if (stall_left > 0) begin
					report_mismatch("fetch_valid high while stalled");
				end
				if (after_redirect) begin
					report_mismatch("fetch_valid high in the cycle after a redirect");
				end
				if (fetch_pc !== exp_pc) begin
					report_mismatch($sformatf("fetch_pc %h, expected %h", fetch_pc, exp_pc));
				end
				if (fetch_inst !== exp_words[exp_pc[15:2]]) begin
					report_mismatch($sformatf("fetch_inst %h at pc %h, expected %h",
						fetch_inst, exp_pc, exp_words[exp_pc[15:2]]));
				end
				exp_pc = exp_pc + 4;
				fetches++;
				idle = 0;
			end else begin
				idle++;
			end
			after_redirect = 1'b0;
			if (stall_left > 0) begin
				stall_left--;
				if (stall_left == 0) begin
					stall = 1'b0;
				end
			end
			// scripted event right after its fetch
			if (fetch_valid === 1'b1 && ev < n_events && fetches == ev_at[ev]) begin
				if (ev_kind[ev] == "r") begin
					finish_test($sformatf("run to redirect %h at fetch %0d",
						ev_arg[ev], fetches));
					redirect_valid = 1'b1;
					redirect_pc = ev_arg[ev];
					exp_pc = ev_arg[ev];
					after_redirect = 1'b1;
				end else begin
					finish_test($sformatf("run to stall of %0d at fetch %0d",
						ev_arg[ev], fetches));
					stall = 1'b1;
					stall_left = ev_arg[ev];
				end
				ev++;
			end
			if (idle > fetch_timeout || cycles > run_limit) begin
				$display("timeout: no fetch for %0d cycles, waiting for pc %h", idle, exp_pc);
				timed_out = 1'b1;
			end
		end
		finish_test($sformatf("run to end at fetch %0d", fetches));

		$display("tests %0d, failed %0d, errors %0d, loads %0d, refused cycles %0d",
			tests_run, tests_failed, errors, loads, refusals);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/mem_model.sv
/*
 * tagged memory model for the fetch testbench
 * refuses loads at random, replies after a random delay
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module mem_model (
	input  logic                         clock,
	input  logic                         rst_n,
	input  ifetch_pkg::mem_command_e     mem_command,
	input  logic [`IF_XLEN-1:0]          mem_addr,
	output logic [`IF_MEM_TAG_BITS-1:0]  mem_response,
	output logic [`IF_MEM_TAG_BITS-1:0]  mem_tag,
	output logic [`IF_BLOCK_BITS-1:0]    mem_data_in
);

	// 64 KB image with one entry per word
	logic [`IF_XLEN-1:0] words [16384];

	// one outstanding load at most
	logic                        busy;
	logic [`IF_MEM_TAG_BITS-1:0] next_tag;
	logic [`IF_MEM_TAG_BITS-1:0] reply_tag;
	logic [`IF_XLEN-1:0]         reply_addr;
	int unsigned                 delay;
	int unsigned                 seed_val;

	task automatic clear_image();
		for (int i = 0; i < 16384; i++) begin
			words[i] = '0;
		end
	endtask

	task automatic put_word(input logic [31:0] addr, input logic [31:0] data);
		words[addr[15:2]] = data;
	endtask

	////////////////////
	// bus side driven on the falling edge
	////////////////////

	initial begin
		mem_response = '0;
		mem_tag      = '0;
		mem_data_in  = '1;
		busy         = 1'b0;
		next_tag     = 1;
		// all refusals and delays come from this one seed
		seed_val     = 31;
		seed_val     = $urandom(seed_val);
		forever begin
			@(negedge clock);
			mem_response = '0;
			mem_tag      = '0;
			mem_data_in  = '1;
			if (!rst_n) begin
				busy     = 1'b0;
				next_tag = 1;
			end else if (busy) begin
				if (delay == 0) begin
					// upper word at addr+4 and lower word at addr
					mem_tag     = reply_tag;
					mem_data_in = {words[{reply_addr[15:3], 1'b1}],
						words[{reply_addr[15:3], 1'b0}]};
					busy        = 1'b0;
				end else begin
					delay = delay - 1;
					// decoy tag with junk data that must not fill
					if ($urandom % 4 == 0) begin
						mem_tag = reply_tag + 1'b1;
					end
				end
			end else if (mem_command == ifetch_pkg::cmd_load) begin
				// zero response is a refusal
				if ($urandom % 3 != 0) begin
					mem_response = next_tag;
					reply_tag    = next_tag;
					reply_addr   = mem_addr;
					delay        = 1 + $urandom % 5;
					busy         = 1'b1;
					next_tag     = (next_tag == '1) ? 1 : next_tag + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/ifetch_top.sv
/*
 * instruction fetch front end
 * fetch stage, cache controller and cache arrays
 * on a tagged memory bus
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module ifetch_top (
	input  logic                         clock,
	input  logic                         rst_n,

	// control
	input  logic                         stall,
	input  logic                         redirect_valid,
	input  logic [`IF_XLEN-1:0]          redirect_pc,

	// memory bus
	output ifetch_pkg::mem_command_e     mem_command,
	output logic [`IF_XLEN-1:0]          mem_addr,
	output logic [`IF_BLOCK_BITS-1:0]    mem_data,
	output logic [1:0]                   mem_size,
	input  logic [`IF_MEM_TAG_BITS-1:0]  mem_response,
	input  logic [`IF_MEM_TAG_BITS-1:0]  mem_tag,
	input  logic [`IF_BLOCK_BITS-1:0]    mem_data_in,

	// fetch output
	output logic                         fetch_valid,
	output logic [`IF_XLEN-1:0]          fetch_pc,
	output logic [`IF_XLEN-1:0]          fetch_inst
);

	// fetch to controller
	logic [`IF_XLEN-1:0] fetch_addr;
	logic [`IF_XLEN-1:0] inst_word;
	logic                inst_hit;

	// controller to arrays
	icache_if cache_bus ();

	// loads only, always a full block
	assign mem_data = '0;
	assign mem_size = `IF_MEM_SIZE_DOUBLE;

	////////////////////
	// fetch
	////////////////////

	fetch_stage fetch_stage_inst (
		.clock          (clock),
		.rst_n          (rst_n),
		.stall          (stall),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.fetch_addr     (fetch_addr),
		.inst_word      (inst_word),
		.inst_hit       (inst_hit),
		.fetch_valid    (fetch_valid),
		.fetch_pc       (fetch_pc),
		.fetch_inst     (fetch_inst)
	);

	////////////////////
	// icache
	////////////////////

	icache_ctrl icache_ctrl_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.fetch_addr   (fetch_addr),
		.inst_word    (inst_word),
		.inst_hit     (inst_hit),
		.cache        (cache_bus.ctrl),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data_in  (mem_data_in)
	);

	icache_mem icache_mem_inst (
		.clock (clock),
		.rst_n (rst_n),
		.cache (cache_bus.mem)
	);

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
/*
 * fetch stage
 * program counter with redirect and stall, registered fetch output
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module fetch_stage (
	input  logic                clock,
	input  logic                rst_n,

	// control
	input  logic                stall,
	input  logic                redirect_valid,
	input  logic [`IF_XLEN-1:0] redirect_pc,

	// cache lookup
	output logic [`IF_XLEN-1:0] fetch_addr,
	input  logic [`IF_XLEN-1:0] inst_word,
	input  logic                inst_hit,

	// fetch output
	output logic                fetch_valid,
	output logic [`IF_XLEN-1:0] fetch_pc,
	output logic [`IF_XLEN-1:0] fetch_inst
);

	logic [`IF_XLEN-1:0] pc;
	// hit accepted this cycle
	logic                take;

	// redirect wins over a hit in the same cycle
	assign take = inst_hit && !stall && !redirect_valid;

	// pc drives the cache lookup directly
	assign fetch_addr = pc;

	////////////////////
	// program counter
	////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc          <= `IF_RESET_PC;
			fetch_valid <= 1'b0;
		end else if (redirect_valid) begin
			// no output in the cycle after a redirect
			pc          <= redirect_pc;
			fetch_valid <= 1'b0;
		end else if (take) begin
			pc          <= pc + `IF_XLEN'd4;
			fetch_valid <= 1'b1;
		end else begin
			// miss or stall, pc holds
			fetch_valid <= 1'b0;
		end
	end

	////////////////////
	// output register
	////////////////////

	always_ff @(posedge clock) begin
		if (take) begin
			fetch_pc   <= pc;
			fetch_inst <= inst_word;
		end
	end

endmodule

`default_nettype wire

//--- hdl/icache_ctrl.sv
/*
 * instruction cache controller
 * hit path word select, block load requests on the tagged
 * memory bus and cache fill on the matching reply tag
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module icache_ctrl (
	input  logic                         clock,
	input  logic                         rst_n,

	// fetch side
	input  logic [`IF_XLEN-1:0]          fetch_addr,
	output logic [`IF_XLEN-1:0]          inst_word,
	output logic                         inst_hit,

	// cache arrays
	icache_if.ctrl                       cache,

	// memory bus
	output ifetch_pkg::mem_command_e     mem_command,
	output logic [`IF_XLEN-1:0]          mem_addr,
	input  logic [`IF_MEM_TAG_BITS-1:0]  mem_response,
	input  logic [`IF_MEM_TAG_BITS-1:0]  mem_tag,
	input  logic [`IF_BLOCK_BITS-1:0]    mem_data_in
);

	// address split: offset, index, tag
	localparam int off_bits = $clog2(`IF_BLOCK_BITS / 8);
	localparam int idx_lo   = off_bits;
	localparam int idx_hi   = idx_lo + `IF_INDEX_BITS - 1;
	localparam int tag_lo   = idx_hi + 1;
	localparam int tag_hi   = tag_lo + `IF_TAG_BITS - 1;

	ifetch_pkg::icache_state_e state;
	ifetch_pkg::icache_state_e state_next;

	// block address of the outstanding miss
	logic [`IF_XLEN-1:0]         miss_addr;
	// tag given when memory took the request
	logic [`IF_MEM_TAG_BITS-1:0] pend_tag;

	logic start_miss;
	logic accepted;
	logic reply_match;

	////////////////////
	// hit path
	////////////////////

	assign cache.rd_idx = fetch_addr[idx_hi:idx_lo];
	assign cache.rd_tag = fetch_addr[tag_hi:tag_lo];

	// upper or lower word of the block
	assign inst_word = fetch_addr[off_bits-1] ?
		cache.rd_data[`IF_BLOCK_BITS-1 -: `IF_XLEN] :
		cache.rd_data[`IF_XLEN-1:0];
	assign inst_hit = cache.rd_hit;

	////////////////////
	// miss sequencing
	////////////////////

	assign start_miss  = (state == ifetch_pkg::st_idle) && !cache.rd_hit;
	// zero response is a refusal
	assign accepted    = (state == ifetch_pkg::st_request) && (mem_response != '0);
	assign reply_match = (state == ifetch_pkg::st_wait_data) && (mem_tag == pend_tag);

	always_comb begin
		state_next = state;
		case (state)
			ifetch_pkg::st_idle: begin
				if (start_miss) begin
					state_next = ifetch_pkg::st_request;
				end
			end
			ifetch_pkg::st_request: begin
				if (accepted) begin
					state_next = ifetch_pkg::st_wait_data;
				end
			end
			ifetch_pkg::st_wait_data: begin
				// fill still completes across a redirect
				if (reply_match) begin
					state_next = ifetch_pkg::st_idle;
				end
			end
			default: begin
				state_next = ifetch_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ifetch_pkg::st_idle;
			miss_addr <= '0;
		end else begin
			state <= state_next;
			// block aligned, held through request
			if (start_miss) begin
				miss_addr <= {fetch_addr[`IF_XLEN-1:off_bits], {off_bits{1'b0}}};
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accepted) begin
			pend_tag <= mem_response;
		end
	end

	// request stays on the bus until taken
	assign mem_command = (state == ifetch_pkg::st_request) ?
		ifetch_pkg::cmd_load : ifetch_pkg::cmd_none;
	assign mem_addr = miss_addr;

	////////////////////
	// fill
	////////////////////

	assign cache.wr_en   = reply_match;
	assign cache.wr_idx  = miss_addr[idx_hi:idx_lo];
	assign cache.wr_tag  = miss_addr[tag_hi:tag_lo];
	assign cache.wr_data = mem_data_in;

endmodule

`default_nettype wire

//--- hdl/icache_mem.sv
/*
 * instruction cache arrays
 * direct mapped data, tag and valid storage
 * combinational lookup with tag compare, one block fill per cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

module icache_mem (
	input  logic    clock,
	input  logic    rst_n,
	icache_if.mem   cache
);

	// one entry per block
	logic [`IF_BLOCK_BITS-1:0] data_array [`IF_LINES];
	logic [`IF_TAG_BITS-1:0]   tag_array  [`IF_LINES];
	logic [`IF_LINES-1:0]      valid_bits;

	////////////////////
	// lookup
	////////////////////

	assign cache.rd_data = data_array[cache.rd_idx];

	// hit needs a filled entry with the same tag
	assign cache.rd_hit = valid_bits[cache.rd_idx] &&
		(tag_array[cache.rd_idx] == cache.rd_tag);

	////////////////////
	// fill
	////////////////////

	// valid bits, all clear out of reset
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
		end else if (cache.wr_en) begin
			valid_bits[cache.wr_idx] <= 1'b1;
		end
	end

	// block and tag written together
	always_ff @(posedge clock) begin
		if (cache.wr_en) begin
			data_array[cache.wr_idx] <= cache.wr_data;
			tag_array[cache.wr_idx]  <= cache.wr_tag;
		end
	end

endmodule

`default_nettype wire

//--- hdl/icache_if.sv
/*
 * instruction cache memory port bundle
 * lookup and fill between the controller and the arrays
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifetch_macros.svh"

interface icache_if;

	// lookup, set by the controller
	logic [`IF_INDEX_BITS-1:0] rd_idx;
	logic [`IF_TAG_BITS-1:0]   rd_tag;

	// lookup result from the arrays
	logic [`IF_BLOCK_BITS-1:0] rd_data;
	logic                      rd_hit;

	// block fill from a memory reply
	logic                      wr_en;
	logic [`IF_INDEX_BITS-1:0] wr_idx;
	logic [`IF_TAG_BITS-1:0]   wr_tag;
	logic [`IF_BLOCK_BITS-1:0] wr_data;

	// controller side
	modport ctrl (
		output rd_idx,
		output rd_tag,
		output wr_en,
		output wr_idx,
		output wr_tag,
		output wr_data,
		input  rd_data,
		input  rd_hit
	);

	// array side
	modport mem (
		input  rd_idx,
		input  rd_tag,
		input  wr_en,
		input  wr_idx,
		input  wr_tag,
		input  wr_data,
		output rd_data,
		output rd_hit
	);

endinterface

`default_nettype wire

//--- hdl/ifetch_pkg.sv
/*
 * instruction fetch types
 * memory bus opcodes and cache controller states
 */

`default_nettype none

package ifetch_pkg;

	////////////////////
	// memory bus
	////////////////////

	// store kept only for the bus encoding
	typedef enum logic [1:0] {
		cmd_none  = 2'h0,
		cmd_load  = 2'h1,
		cmd_store = 2'h2
	} mem_command_e;

	////////////////////
	// cache controller
	////////////////////

	// idle: serving hits
	// request: load on the bus until accepted
	// wait_data: waiting for the matching reply tag
	typedef enum logic [1:0] {
		st_idle      = 2'h0,
		st_request   = 2'h1,
		st_wait_data = 2'h2
	} icache_state_e;

endpackage

`default_nettype wire

//--- hdl/ifetch_macros.svh
/*
 * instruction fetch front end
 * widths and constants shared by all blocks
 */

`ifndef IFETCH_MACROS_SVH
`define IFETCH_MACROS_SVH

// address and instruction width
`define IF_XLEN 32

// cache block and memory bus data width
`define IF_BLOCK_BITS 64

// direct mapped cache geometry
// index from pc bits 7..3, tag from pc bits 15..8 (64 KB space)
`define IF_INDEX_BITS 5
`define IF_TAG_BITS 8
`define IF_LINES 32

// memory transaction tag, zero means no transaction
`define IF_MEM_TAG_BITS 4

// bus size code for a double word transfer
`define IF_MEM_SIZE_DOUBLE 2'h3

`define IF_RESET_PC 32'h0000_0000

`endif
